// ==== Makefile ====
SIM = obj_dir/Vtb_softex

.PHONY: all run clean

all: run

$(SIM): src.f $(shell grep -v '^+' src.f) include/softex_tb_model.svh
	verilator --binary --timing -Wno-fatal --top-module tb_softex -f src.f -o Vtb_softex

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^test passed$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src.f ====
+incdir+include
src/softex_fmt_pkg.sv
src/softex_cfg_pkg.sv
src/softex_exp_unit.sv
src/softex_max_stage.sv
src/softex_exp_stage.sv
src/softex_denom_acc.sv
src/softex_top.sv
test/tb_softex.sv

// ==== src/softex_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Geometry of the denominator datapath. The accumulator saturates at its
// all-ones value, so a very long row pins the denominator.
////////////////////////////////////////////////////////////////////////////
package softex_cfg_pkg;

    localparam int unsigned N_LANES = 4;

    // Four lanes of at most EXP_ONE each
    localparam int unsigned SUM_W   = 18;

    // Same 2^-15 units as the lane sum
    localparam int unsigned ACC_W   = 28;

    // Smallest Q4.4 score
    localparam int MAX_INIT = -128;

endpackage

// ==== src/softex_denom_acc.sv ====
////////////////////////////////////////////////////////////////////////////
// Third stage. denom = (denom * factor) >> 15 + lane sum, truncating the
// product and saturating the result at the all-ones value.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module softex_denom_acc import softex_fmt_pkg::*, softex_cfg_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          clear_i,
    input  logic                          valid_i,
    input  logic [N_LANES-1:0][EXP_W-1:0] exp_i,
    input  logic [EXP_W-1:0]              factor_i,
    output logic [ACC_W-1:0]              denom_o,
    output logic                          valid_o
);

    logic [SUM_W-1:0]                   lane_sum;
    logic [ACC_W+EXP_W-1:0]             product;
    logic [ACC_W+EXP_W-EXP_SHIFT-1:0]   scaled;
    logic [ACC_W+1:0]                   total;
    logic [ACC_W-1:0]                   denom_next;

    // Lane reduction
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            lane_sum = lane_sum + SUM_W'(exp_i[i]);
        end
    end

    assign product = denom_o * factor_i;
    assign scaled  = product[ACC_W+EXP_W-1:EXP_SHIFT];
    assign total   = (ACC_W+2)'(scaled) + (ACC_W+2)'(lane_sum);

    always_comb begin
        if (total[ACC_W+1:ACC_W] != 2'b00) begin
            denom_next = '1;
        end else begin
            denom_next = total[ACC_W-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            denom_o <= '0;
            valid_o <= 1'b0;
        end else if (clear_i) begin
            denom_o <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                denom_o <= denom_next;
            end
        end
    end

endmodule

// ==== src/softex_exp_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Second stage. Lane exponentials relative to the new maximum and the
// rescale factor from old to new maximum. Unstrobed lanes give zero.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module softex_exp_stage import softex_fmt_pkg::*, softex_cfg_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            clear_i,
    input  logic                            valid_i,
    input  logic [N_LANES-1:0]              strb_i,
    input  logic [N_LANES-1:0][SCORE_W-1:0] score_i,
    input  logic signed [SCORE_W-1:0]       old_max_i,
    input  logic signed [SCORE_W-1:0]       new_max_i,
    output logic                            valid_o,
    output logic [N_LANES-1:0][EXP_W-1:0]   exp_o,
    output logic [EXP_W-1:0]                factor_o
);

    diff_t            lane_diff [N_LANES];
    diff_t            scal_diff;
    logic [EXP_W-1:0] lane_exp  [N_LANES];
    logic [EXP_W-1:0] scal_exp;

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        assign lane_diff[i].raw = DIFF_W'($signed(score_i[i])) - DIFF_W'(new_max_i);

        softex_exp_unit i_lane_exp (
            .diff_i ( lane_diff[i] ),
            .exp_o  ( lane_exp[i]  )
        );
    end

    // Zero while the maximum holds, so the factor is exactly 1.0 then
    assign scal_diff.raw = DIFF_W'(old_max_i) - DIFF_W'(new_max_i);

    softex_exp_unit i_scal_exp (
        .diff_i ( scal_diff ),
        .exp_o  ( scal_exp  )
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            for (int i = 0; i < N_LANES; i++) begin
                exp_o[i] <= strb_i[i] ? lane_exp[i] : '0;
            end
            factor_o <= scal_exp;
        end
    end

endmodule

// ==== src/softex_exp_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Base-2 exponential with a linear mantissa. Only valid for inputs <= 0.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module softex_exp_unit import softex_fmt_pkg::*; (
    input  diff_t            diff_i,
    output logic [EXP_W-1:0] exp_o
);

    logic [EXP_W-1:0]         mant;
    logic [DIFF_W-FRAC_W-1:0] shamt;

    // 2^f is taken as 1 + f, so the fraction lands just below the unit bit
    assign mant = EXP_ONE + (EXP_W'(diff_i.fields.frac) << (EXP_SHIFT - FRAC_W));

    // Integer part lies in -16..0 and its negation fits unsigned
    assign shamt = -diff_i.fields.int_part;

    always_comb begin
        if (int'(shamt) > EXP_SHIFT) begin
            exp_o = '0;
        end else begin
            exp_o = mant >> shamt;
        end
    end

endmodule

// ==== src/softex_fmt_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Scores are signed Q4.4 and exponentials are unsigned Q1.15.
// Differences handed to the exponential are assumed to be non-positive.
////////////////////////////////////////////////////////////////////////////
package softex_fmt_pkg;

    localparam int unsigned SCORE_W   = 8;
    localparam int unsigned FRAC_W    = 4;
    // One extra bit so that a difference of two scores cannot overflow
    localparam int unsigned DIFF_W    = SCORE_W + 1;

    localparam int unsigned EXP_W     = 16;
    localparam int unsigned EXP_SHIFT = 15;
    localparam logic [EXP_W-1:0] EXP_ONE = 16'd32768;

    // Same nine bits, seen as a plain signed value or split at the binary point
    typedef union packed {
        logic signed [DIFF_W-1:0] raw;
        struct packed {
            logic signed [DIFF_W-FRAC_W-1:0] int_part;
            logic [FRAC_W-1:0]               frac;
        } fields;
    } diff_t;

endpackage

// ==== src/softex_max_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// First stage. Tracks the running maximum over strobed lanes only.
// Clear wins over a vector sampled in the same cycle.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module softex_max_stage import softex_fmt_pkg::*, softex_cfg_pkg::*; (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              clear_i,
    input  logic                              in_valid_i,
    input  logic [N_LANES-1:0]                in_strb_i,
    input  logic [N_LANES-1:0][SCORE_W-1:0]   in_score_i,
    output logic signed [SCORE_W-1:0]         max_o,
    output logic                              valid_o,
    output logic [N_LANES-1:0]                strb_o,
    output logic [N_LANES-1:0][SCORE_W-1:0]   score_o,
    output logic signed [SCORE_W-1:0]         old_max_o,
    output logic signed [SCORE_W-1:0]         new_max_o
);

    logic signed [SCORE_W-1:0] max_q;
    logic signed [SCORE_W-1:0] cand_max;
    logic                      valid_q;

    // Compare every strobed lane against the running value
    always_comb begin
        cand_max = max_q;
        for (int i = 0; i < N_LANES; i++) begin
            if (in_strb_i[i] && ($signed(in_score_i[i]) > cand_max)) begin
                cand_max = $signed(in_score_i[i]);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            max_q   <= SCORE_W'(MAX_INIT);
            valid_q <= 1'b0;
        end else if (clear_i) begin
            max_q   <= SCORE_W'(MAX_INIT);
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                max_q <= cand_max;
            end
        end
    end

    // Vector payload together with the maximum before and after it
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            strb_o    <= in_strb_i;
            score_o   <= in_score_i;
            old_max_o <= max_q;
            new_max_o <= cand_max;
        end
    end

    assign max_o   = max_q;
    assign valid_o = valid_q;

endmodule

// ==== src/softex_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Softmax denominator engine, three stages, no back-pressure.
// valid_o pulses three rising edges after a vector is sampled.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module softex_top import softex_fmt_pkg::*, softex_cfg_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            clear_i,
    input  logic                            in_valid_i,
    input  logic [N_LANES-1:0]              in_strb_i,
    input  logic [N_LANES-1:0][SCORE_W-1:0] in_score_i,
    output logic signed [SCORE_W-1:0]       max_o,
    output logic [ACC_W-1:0]                denom_o,
    output logic                            valid_o,
    output logic                            busy_o
);

    logic                            s1_valid;
    logic [N_LANES-1:0]              s1_strb;
    logic [N_LANES-1:0][SCORE_W-1:0] s1_score;
    logic signed [SCORE_W-1:0]       s1_old_max;
    logic signed [SCORE_W-1:0]       s1_new_max;

    logic                            s2_valid;
    logic [N_LANES-1:0][EXP_W-1:0]   s2_exp;
    logic [EXP_W-1:0]                s2_factor;

    softex_max_stage i_max_stage (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .clear_i    ( clear_i    ),
        .in_valid_i ( in_valid_i ),
        .in_strb_i  ( in_strb_i  ),
        .in_score_i ( in_score_i ),
        .max_o      ( max_o      ),
        .valid_o    ( s1_valid   ),
        .strb_o     ( s1_strb    ),
        .score_o    ( s1_score   ),
        .old_max_o  ( s1_old_max ),
        .new_max_o  ( s1_new_max )
    );

    softex_exp_stage i_exp_stage (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .clear_i   ( clear_i    ),
        .valid_i   ( s1_valid   ),
        .strb_i    ( s1_strb    ),
        .score_i   ( s1_score   ),
        .old_max_i ( s1_old_max ),
        .new_max_i ( s1_new_max ),
        .valid_o   ( s2_valid   ),
        .exp_o     ( s2_exp     ),
        .factor_o  ( s2_factor  )
    );

    softex_denom_acc i_denom_acc (
        .clk_i    ( clk_i     ),
        .rst_ni   ( rst_ni    ),
        .clear_i  ( clear_i   ),
        .valid_i  ( s2_valid  ),
        .exp_i    ( s2_exp    ),
        .factor_i ( s2_factor ),
        .denom_o  ( denom_o   ),
        .valid_o  ( valid_o   )
    );

    assign busy_o = s1_valid | s2_valid | valid_o;

endmodule

// ==== include/softex_tb_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reference model of the denominator engine and a 32-bit Galois LFSR.
// Needs softex_fmt_pkg and softex_cfg_pkg compiled before it.
////////////////////////////////////////////////////////////////////////////
`ifndef SOFTEX_TB_MODEL_SVH
`define SOFTEX_TB_MODEL_SVH

// Linear-mantissa 2^diff for diff in Q4.4 units and not above zero
function automatic int exp2_lin(input int diff);
    int n;
    int f;
    int mant;
    n    = diff >>> softex_fmt_pkg::FRAC_W;
    f    = diff & ((1 << softex_fmt_pkg::FRAC_W) - 1);
    mant = int'(softex_fmt_pkg::EXP_ONE) + f * 2048;
    if (-n > softex_fmt_pkg::EXP_SHIFT) return 0;
    return mant >> (-n);
endfunction

// Absorbs one vector into the running maximum and denominator
function automatic void advance_model(
    input logic [softex_cfg_pkg::N_LANES-1:0]                        strb,
    input logic [softex_cfg_pkg::N_LANES*softex_fmt_pkg::SCORE_W-1:0] scores,
    inout int                                                        max_v,
    inout longint                                                    denom_v
);
    int     old_max;
    int     sc;
    longint sum;
    longint acc_max;
    acc_max = (longint'(1) << softex_cfg_pkg::ACC_W) - 1;
    old_max = max_v;
    sum     = 0;
    for (int i = 0; i < softex_cfg_pkg::N_LANES; i++) begin
        sc = $signed(scores[i*softex_fmt_pkg::SCORE_W +: softex_fmt_pkg::SCORE_W]);
        if (strb[i] && sc > max_v) max_v = sc;
    end
    for (int i = 0; i < softex_cfg_pkg::N_LANES; i++) begin
        sc = $signed(scores[i*softex_fmt_pkg::SCORE_W +: softex_fmt_pkg::SCORE_W]);
        if (strb[i]) sum = sum + exp2_lin(sc - max_v);
    end
    denom_v = ((denom_v * exp2_lin(old_max - max_v)) >> softex_fmt_pkg::EXP_SHIFT) + sum;
    if (denom_v > acc_max) denom_v = acc_max;
endfunction

// Galois form of x^32 + x^22 + x^2 + x + 1 with one step per bit taken
function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val   = {val[30:0], state[0]};
        state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    end
    return val;
endfunction

`endif

// ==== test/tb_softex.sv ====
////////////////////////////////////////////////////////////////////////////
// Directed tests of the denominator engine against the included model.
// Inputs change 2 ns after each rising edge. Outputs are sampled there too.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_softex import softex_fmt_pkg::*, softex_cfg_pkg::*; ();

    `include "softex_tb_model.svh"

    localparam int TIMEOUT = 20;
    localparam int N_RAND  = 20;

    logic                            clk_i;
    logic                            rst_ni;
    logic                            clear_i;
    logic                            in_valid_i;
    logic [N_LANES-1:0]              in_strb_i;
    logic [N_LANES-1:0][SCORE_W-1:0] in_score_i;
    logic signed [SCORE_W-1:0]       max_o;
    logic [ACC_W-1:0]                denom_o;
    logic                            valid_o;
    logic                            busy_o;

    string       cur_test;
    int          test_errors;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          model_max;
    longint      model_denom;
    logic [31:0] lfsr_state;

    softex_top uut (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .clear_i    ( clear_i    ),
        .in_valid_i ( in_valid_i ),
        .in_strb_i  ( in_strb_i  ),
        .in_score_i ( in_score_i ),
        .max_o      ( max_o      ),
        .denom_o    ( denom_o    ),
        .valid_o    ( valid_o    ),
        .busy_o     ( busy_o     )
    );

    always #10 clk_i = ~clk_i;

    task automatic check_value(input string what, input longint expected, input longint actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("[PASS] %s", cur_test);
            tests_ok++;
        end else begin
            $display("[DONE] %s with %0d errors", cur_test, test_errors);
            tests_bad++;
        end
        errors += test_errors;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic clear_row();
        clear_i = 1'b1;
        next_cycle();
        clear_i     = 1'b0;
        model_max   = MAX_INIT;
        model_denom = 0;
    endtask

    // Presents a vector and lets the model absorb it
    task automatic drive_inputs(input logic [N_LANES-1:0] strb,
                                input logic [N_LANES-1:0][SCORE_W-1:0] scores);
        in_valid_i = 1'b1;
        in_strb_i  = strb;
        in_score_i = scores;
        advance_model(strb, scores, model_max, model_denom);
    endtask

    task automatic send_vector(input logic [N_LANES-1:0] strb,
                               input logic [N_LANES-1:0][SCORE_W-1:0] scores);
        drive_inputs(strb, scores);
        next_cycle();
        in_valid_i = 1'b0;
    endtask

    // Edges counted after the sampling edge
    task automatic wait_valid(output int edges);
        edges = 0;
        while (!valid_o && edges < TIMEOUT) begin
            next_cycle();
            edges++;
        end
        assert (valid_o) else begin
            $display("%s: valid_o did not rise within %0d cycles", cur_test, TIMEOUT);
            test_errors++;
        end
    endtask

    task automatic absorb(input logic [N_LANES-1:0] strb,
                          input logic [N_LANES-1:0][SCORE_W-1:0] scores);
        int edges;
        send_vector(strb, scores);
        wait_valid(edges);
        check_value("denom", model_denom, longint'(denom_o));
        check_value("max", model_max, longint'(max_o));
        next_cycle();
        check_value("valid_o after pulse", 0, longint'(valid_o));
    endtask

    task automatic reset_state();
        begin_test("reset_state");
        check_value("valid_o", 0, longint'(valid_o));
        check_value("busy_o", 0, longint'(busy_o));
        check_value("denom", 0, longint'(denom_o));
        check_value("max", MAX_INIT, longint'(max_o));
        end_test();
    endtask

    task automatic single_vector();
        int edges;
        begin_test("single_vector");
        clear_row();
        send_vector(4'b1111, {4{8'h18}});
        check_value("max", 24, longint'(max_o));
        check_value("busy_o in flight", 1, longint'(busy_o));
        wait_valid(edges);
        // Sampling edge plus two more
        check_value("latency", 3, edges + 1);
        check_value("denom", 4 * longint'(EXP_ONE), longint'(denom_o));
        next_cycle();
        check_value("valid_o after pulse", 0, longint'(valid_o));
        end_test();
    endtask

    task automatic rising_max();
        begin_test("rising_max");
        clear_row();
        absorb(4'b1111, {8'h08, 8'hf0, 8'h10, 8'h00});
        absorb(4'b1111, {8'h24, 8'h10, 8'he8, 8'h18});
        absorb(4'b1111, {8'h20, 8'h38, 8'h02, 8'hc0});
        end_test();
    endtask

    task automatic lane_strobes();
        longint denom_before;
        begin_test("lane_strobes");
        clear_row();
        absorb(4'b1111, {4{8'h10}});
        // Lane 2 carries the largest score but is masked
        absorb(4'b1011, {8'h08, 8'h70, 8'h10, 8'hf8});
        check_value("masked max", 16, longint'(max_o));
        denom_before = denom_o;
        absorb(4'b0000, {4{8'h7f}});
        check_value("denom kept", denom_before, longint'(denom_o));
        end_test();
    endtask

    task automatic random_stream();
        logic [N_LANES-1:0]              strb;
        logic [N_LANES-1:0][SCORE_W-1:0] scores;
        logic [31:0]                     rnd;
        int                              sent;
        int                              pulses;
        int                              cycles;
        begin_test("random_stream");
        clear_row();
        sent   = 0;
        pulses = 0;
        cycles = 0;
        while (pulses < N_RAND && cycles < N_RAND + TIMEOUT) begin
            if (sent < N_RAND) begin
                rnd  = lfsr_bits(lfsr_state, N_LANES);
                strb = rnd[N_LANES-1:0];
                for (int i = 0; i < N_LANES; i++) begin
                    rnd       = lfsr_bits(lfsr_state, SCORE_W);
                    scores[i] = rnd[SCORE_W-1:0];
                end
                drive_inputs(strb, scores);
                sent++;
            end else begin
                in_valid_i = 1'b0;
            end
            next_cycle();
            cycles++;
            if (valid_o) pulses++;
        end
        in_valid_i = 1'b0;
        assert (pulses == N_RAND) else begin
            $display("%s: only %0d of %0d valid_o pulses seen", cur_test, pulses, N_RAND);
            test_errors++;
        end
        check_value("denom", model_denom, longint'(denom_o));
        check_value("max", model_max, longint'(max_o));
        clear_row();
        check_value("max after clear", MAX_INIT, longint'(max_o));
        check_value("denom after clear", 0, longint'(denom_o));
        check_value("busy_o after clear", 0, longint'(busy_o));
        end_test();
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_strb_i   = '0;
        in_score_i  = '0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        model_max   = MAX_INIT;
        model_denom = 0;
        lfsr_state  = 32'h523a_d0d5;
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        reset_state();
        single_vector();
        rising_max();
        lane_strobes();
        random_stream();
        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
